// File: design/periph_addr_decoder.sv
// module periph_addr_decoder: bus strobe and address to info, irq and per-channel strobes
`timescale 1ns/10ps
`default_nettype none

module periph_addr_decoder #(
    parameter int num_channels = 4
) (
    input  wire                            enable,
    input  wire                            write_en,
    input  wire [periph_pkg::addr_w-1:0]   addr,
    input  wire [periph_pkg::data_w-1:0]   data_in,
    output logic                           info_rd,
    output logic                           irq_rd,
    timer_reg_if.decoder                   chan [num_channels]
);

    localparam int idx_w = periph_pkg::addr_w - 2;
    // size of the channel range in bytes
    localparam logic [periph_pkg::addr_w-1:0] chan_limit =
        (periph_pkg::addr_w)'(periph_pkg::chan_span * num_channels);

    logic                          rd_strobe;
    logic                          wr_strobe;
    logic [periph_pkg::addr_w-1:0] chan_offset;
    logic [idx_w-1:0]              chan_idx;
    logic                          in_range;

    assign rd_strobe = enable & ~write_en;
    assign wr_strobe = enable & write_en;

    // channel address relative to the first channel
    assign chan_offset = addr - periph_pkg::chan_base;
    assign chan_idx    = chan_offset[periph_pkg::addr_w-1:2];
    assign in_range    = (addr >= periph_pkg::chan_base) && (chan_offset < chan_limit);

    // fixed registers ahead of the channels
    assign info_rd = rd_strobe && (addr == periph_pkg::info_offset);
    assign irq_rd  = rd_strobe && (addr == periph_pkg::irq_offset);

    for (genvar i = 0; i < num_channels; i++) begin : g_chan
        localparam logic [idx_w-1:0] this_idx = (idx_w)'(i);
        logic hit;

        assign hit = in_range && (chan_idx == this_idx);

        // at most one channel sees a strobe
        assign chan[i].wr      = wr_strobe & hit;
        assign chan[i].rd      = rd_strobe & hit;
        assign chan[i].reg_sel = chan_offset[1:0];
        assign chan[i].wdata   = data_in;
    end

endmodule

`default_nettype wire

// File: design/periph_pkg.sv
// peripheral package: bus widths, register map, control and status bits, info constant
`default_nettype none

package periph_pkg;

    // bus and counter widths
    localparam int data_w   = 8;
    localparam int addr_w   = 8;
    localparam int reload_w = 16;

    // register map inside the peripheral window
    localparam logic [addr_w-1:0] info_offset = 8'h00;
    localparam logic [addr_w-1:0] irq_offset  = 8'h01;
    localparam logic [addr_w-1:0] chan_base   = 8'h04;
    // bytes per timer channel, must stay a power of two
    localparam int chan_span = 4;

    // per-channel register select, low address bits
    localparam logic [1:0] reg_reload_lo = 2'd0;
    localparam logic [1:0] reg_reload_hi = 2'd1;
    localparam logic [1:0] reg_control   = 2'd2;
    localparam logic [1:0] reg_status    = 2'd3;

    // control byte
    localparam int ctl_run      = 0;
    localparam int ctl_irq_en   = 1;
    localparam int ctl_one_shot = 2;

    // status byte, writing 1 to the flag bit clears it
    localparam int st_flag = 0;
    localparam int st_run  = 1;

    // upper nibble of the info register
    localparam logic [3:0] info_version = 4'h1;

endpackage

`default_nettype wire

// File: design/periph_read_collector.sv
// module periph_read_collector: registered read data and the shared interrupt request
`timescale 1ns/10ps
`default_nettype none

module periph_read_collector #(
    parameter int num_channels = 4
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           info_rd,
    input  wire                           irq_rd,
    timer_reg_if.collector                chan [num_channels],
    output logic [periph_pkg::data_w-1:0] data_out,
    output logic                          interrupt_request
);

    logic [num_channels-1:0]       chan_rd;
    logic [num_channels-1:0]       chan_irq;
    logic [periph_pkg::data_w-1:0] chan_rdata [num_channels];
    logic [periph_pkg::data_w-1:0] chan_data;
    logic [periph_pkg::data_w-1:0] info_byte;
    logic [periph_pkg::data_w-1:0] irq_summary;

    for (genvar i = 0; i < num_channels; i++) begin : g_gather
        assign chan_rd[i]    = chan[i].rd;
        assign chan_irq[i]   = chan[i].irq;
        assign chan_rdata[i] = chan[i].rdata;
    end

    // rd is one-hot, so an OR of the gated bytes selects the channel
    always_comb begin
        chan_data = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (chan_rd[i]) begin
                chan_data = chan_data | chan_rdata[i];
            end
        end
    end

    assign info_byte = {periph_pkg::info_version, 4'(num_channels)};

    // channels past bit 7 show up only in their own status register
    always_comb begin
        irq_summary = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (i < periph_pkg::data_w) begin
                irq_summary[i] = chan_irq[i];
            end
        end
    end

    // data_out is valid the cycle after the strobe, zero otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            data_out          <= '0;
            interrupt_request <= 1'b0;
        end else begin
            if (info_rd) begin
                data_out <= info_byte;
            end else if (irq_rd) begin
                data_out <= irq_summary;
            end else begin
                data_out <= chan_data;
            end
            interrupt_request <= |chan_irq;
        end
    end

endmodule

`default_nettype wire

// File: design/periph_timer_block.sv
// module periph_timer_block: top level with decoder, timer channels and read collector
`timescale 1ns/10ps
`default_nettype none

module periph_timer_block #(
    parameter int num_channels = 4
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           enable,
    input  wire                           write_en,
    input  wire [periph_pkg::addr_w-1:0]  addr,
    input  wire [periph_pkg::data_w-1:0]  data_in,
    output logic [periph_pkg::data_w-1:0] data_out,
    output logic                          interrupt_request,
    output logic [num_channels-1:0]       timer_out
);

    logic info_rd;
    logic irq_rd;

    // one register link per channel
    timer_reg_if chan_link [num_channels] ();

    periph_addr_decoder #(
        .num_channels(num_channels)
    ) decoder_i (
        .enable  (enable),
        .write_en(write_en),
        .addr    (addr),
        .data_in (data_in),
        .info_rd (info_rd),
        .irq_rd  (irq_rd),
        .chan    (chan_link)
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_timer
        periph_timer_channel channel_i (
            .clk      (clk),
            .reset    (reset),
            .bus      (chan_link[i]),
            .timer_out(timer_out[i])
        );
    end

    periph_read_collector #(
        .num_channels(num_channels)
    ) collector_i (
        .clk              (clk),
        .reset            (reset),
        .info_rd          (info_rd),
        .irq_rd           (irq_rd),
        .chan             (chan_link),
        .data_out         (data_out),
        .interrupt_request(interrupt_request)
    );

endmodule

`default_nettype wire

// File: design/periph_timer_channel.sv
// module periph_timer_channel: down counter with reload, control, flag and toggle output
`timescale 1ns/10ps
`default_nettype none

module periph_timer_channel (
    input  wire           clk,
    input  wire           reset,
    timer_reg_if.channel  bus,
    output logic          timer_out
);

    logic [periph_pkg::reload_w-1:0] reload;
    logic [periph_pkg::reload_w-1:0] counter;
    logic [periph_pkg::data_w-1:0]   control;
    logic                            flag;
    logic [periph_pkg::data_w-1:0]   status;

    logic running;
    logic expire;
    logic ctl_write;
    logic start;
    logic flag_clear;

    assign running = control[periph_pkg::ctl_run];
    assign expire  = running && (counter == '0);

    assign ctl_write  = bus.wr && (bus.reg_sel == periph_pkg::reg_control);
    // run going from 0 to 1 restarts the count from the reload value
    assign start      = ctl_write && bus.wdata[periph_pkg::ctl_run] && !running;
    assign flag_clear = bus.wr && (bus.reg_sel == periph_pkg::reg_status)
                        && bus.wdata[periph_pkg::st_flag];

    always_ff @(posedge clk) begin
        if (reset) begin
            reload    <= '0;
            counter   <= '0;
            control   <= '0;
            flag      <= 1'b0;
            timer_out <= 1'b0;
        end else begin
            // counting first, bus writes below take priority
            if (expire) begin
                counter   <= reload;
                timer_out <= ~timer_out;
                if (control[periph_pkg::ctl_one_shot]) begin
                    control[periph_pkg::ctl_run] <= 1'b0;
                end
            end else if (running) begin
                counter <= counter - 1'b1;
            end

            // a new expiry wins over a clear in the same cycle
            flag <= (flag & ~flag_clear) | expire;

            if (bus.wr) begin
                case (bus.reg_sel)
                    periph_pkg::reg_reload_lo: reload[7:0]  <= bus.wdata;
                    periph_pkg::reg_reload_hi: reload[15:8] <= bus.wdata;
                    periph_pkg::reg_control:   control      <= bus.wdata;
                    default: ;
                endcase
            end

            if (start) begin
                counter <= reload;
            end
        end
    end

    // status byte, run is read only
    always_comb begin
        status                      = '0;
        status[periph_pkg::st_flag] = flag;
        status[periph_pkg::st_run]  = running;
    end

    always_comb begin
        case (bus.reg_sel)
            periph_pkg::reg_reload_lo: bus.rdata = reload[7:0];
            periph_pkg::reg_reload_hi: bus.rdata = reload[15:8];
            periph_pkg::reg_control:   bus.rdata = control;
            default:                   bus.rdata = status;
        endcase
    end

    assign bus.irq = flag & control[periph_pkg::ctl_irq_en];

endmodule

`default_nettype wire

// File: design/timer_reg_if.sv
// interface: register link between decoder, one timer channel and the read collector
`timescale 1ns/10ps
`default_nettype none

interface timer_reg_if;

    // decoder side, one-cycle strobes
    logic                          wr;
    logic                          rd;
    logic [1:0]                    reg_sel;
    logic [periph_pkg::data_w-1:0] wdata;

    // channel side
    logic [periph_pkg::data_w-1:0] rdata;
    logic                          irq;

    modport decoder (
        output wr,
        output rd,
        output reg_sel,
        output wdata
    );

    modport channel (
        input  wr,
        input  rd,
        input  reg_sel,
        input  wdata,
        output rdata,
        output irq
    );

    // collector only looks at read traffic and interrupt flags
    modport collector (
        input rd,
        input rdata,
        input irq
    );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the timer block testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f \
    --top-module periph_timer_block_tb -o periph_sim \
    && ./obj_dir/periph_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

grep -q "All tests passed!" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: tb/periph_timer_block_props.sv
// module periph_timer_block_props and its bind: reset state and timer output properties
`timescale 1ns/10ps
`default_nettype none

module periph_timer_block_props #(
    parameter int num_channels = 4
) (
    input wire                          clk,
    input wire                          reset,
    input wire [periph_pkg::data_w-1:0] data_out,
    input wire                          interrupt_request,
    input wire [num_channels-1:0]       timer_out,
    input wire [num_channels-1:0]       run_bits
);

    // registered outputs are zero the cycle after reset is seen
    assert property (@(posedge clk)
        reset |=> (data_out == '0 && !interrupt_request && timer_out == '0))
    else $error("outputs not zero during reset");

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(interrupt_request))
    else $error("interrupt_request is unknown");

    for (genvar i = 0; i < num_channels; i++) begin : g_run
        // one-shot clears run at the toggle edge, so look at the previous cycle
        assert property (@(posedge clk) disable iff (reset)
            (timer_out[i] != $past(timer_out[i])) |-> $past(run_bits[i]))
        else $error("timer_out[%0d] changed while its channel was stopped", i);
    end

endmodule

bind periph_timer_block periph_timer_block_props #(
    .num_channels(num_channels)
) props_i (
    .clk              (clk),
    .reset            (reset),
    .data_out         (data_out),
    .interrupt_request(interrupt_request),
    .timer_out        (timer_out),
    .run_bits         ({g_timer[3].channel_i.running, g_timer[2].channel_i.running,
                        g_timer[1].channel_i.running, g_timer[0].channel_i.running})
);

`default_nettype wire

// File: tb/periph_timer_block_tb.sv
// testbench periph_timer_block_tb: clock, reset, bus tasks, stimulus and checks
`timescale 1ns/10ps
`default_nettype none

module periph_timer_block_tb;

    localparam int num_channels = 4;
    localparam int timeout_cycles = 2000;

    logic                    clk;
    logic                    reset;
    logic                    enable;
    logic                    write_en;
    logic [7:0]              addr;
    logic [7:0]              data_in;
    wire  [7:0]              data_out;
    wire                     interrupt_request;
    wire  [num_channels-1:0] timer_out;

    periph_timer_block #(
        .num_channels(num_channels)
    ) periph_timer_block_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .write_en         (write_en),
        .addr             (addr),
        .data_in          (data_in),
        .data_out         (data_out),
        .interrupt_request(interrupt_request),
        .timer_out        (timer_out)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("Test failures found");
        $fatal(1, "stopping after timeout");
    endtask

    task automatic expect_byte(input logic [7:0] got, input logic [7:0] want,
                               input string what);
        assert (got === want)
        else report_error($sformatf("%s: got %02h, expected %02h", what, got, want));
    endtask

    function automatic logic [7:0] chan_addr(input int ch, input logic [1:0] sel);
        return periph_pkg::chan_base + 8'(4 * ch) + {6'd0, sel};
    endfunction

    // all tasks start and end 2 ns after a rising edge
    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        @(posedge clk);
        #2;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    // data_out is registered at the edge that ends the strobe
    task automatic bus_read(input logic [7:0] a, output logic [7:0] d);
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        @(posedge clk);
        #2;
        enable   = 1'b0;
        d        = data_out;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // counts edges until timer_out of one channel changes
    task automatic wait_toggle(input int ch, output int cycles);
        logic prev;
        prev   = timer_out[ch];
        cycles = 0;
        while (timer_out[ch] === prev) begin
            if (cycles >= timeout_cycles) begin
                report_timeout($sformatf("timer_out[%0d] to toggle", ch));
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        while (interrupt_request !== level) begin
            if (cycles >= timeout_cycles) begin
                report_timeout($sformatf("interrupt_request to become %0b", level));
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic wait_flag(input int ch);
        logic [7:0] st;
        int         cycles;
        cycles = 0;
        bus_read(chan_addr(ch, periph_pkg::reg_status), st);
        while (st[periph_pkg::st_flag] !== 1'b1) begin
            if (cycles >= timeout_cycles) begin
                report_timeout($sformatf("flag of channel %0d", ch));
            end
            bus_read(chan_addr(ch, periph_pkg::reg_status), st);
            cycles++;
        end
    endtask

    initial begin
        logic [7:0]  rd;
        logic [7:0]  lo [num_channels];
        logic [7:0]  hi [num_channels];
        logic [7:0]  ctl [num_channels];
        int unsigned r;
        int          cycles;
        logic        level;

        void'($urandom(32'h882e));
        clk      = 1'b0;
        reset    = 1'b1;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        // info register and unmapped offsets
        bus_read(periph_pkg::info_offset, rd);
        expect_byte(rd, {periph_pkg::info_version, 4'd4}, "info register");
        bus_read(8'h02, rd);
        expect_byte(rd, 8'h00, "unmapped 0x02");
        bus_read(8'h03, rd);
        expect_byte(rd, 8'h00, "unmapped 0x03");
        bus_read(8'h14, rd);
        expect_byte(rd, 8'h00, "unmapped 0x14");
        bus_read(8'hff, rd);
        expect_byte(rd, 8'h00, "unmapped 0xff");

        // write every channel first, then read all back
        for (int ch = 0; ch < num_channels; ch++) begin
            lo[ch]  = 8'($urandom);
            hi[ch]  = 8'($urandom);
            ctl[ch] = 8'($urandom) & 8'hfe;
            bus_write(chan_addr(ch, periph_pkg::reg_reload_lo), lo[ch]);
            bus_write(chan_addr(ch, periph_pkg::reg_reload_hi), hi[ch]);
            bus_write(chan_addr(ch, periph_pkg::reg_control), ctl[ch]);
        end
        for (int ch = 0; ch < num_channels; ch++) begin
            bus_read(chan_addr(ch, periph_pkg::reg_reload_lo), rd);
            expect_byte(rd, lo[ch], $sformatf("reload_lo of channel %0d", ch));
            bus_read(chan_addr(ch, periph_pkg::reg_reload_hi), rd);
            expect_byte(rd, hi[ch], $sformatf("reload_hi of channel %0d", ch));
            bus_read(chan_addr(ch, periph_pkg::reg_control), rd);
            expect_byte(rd, ctl[ch], $sformatf("control of channel %0d", ch));
            bus_write(chan_addr(ch, periph_pkg::reg_control), 8'h00);
        end

        // periodic toggle on channel 0
        r = 2 + ($urandom % 19);
        bus_write(chan_addr(0, periph_pkg::reg_reload_lo), 8'(r));
        bus_write(chan_addr(0, periph_pkg::reg_reload_hi), 8'h00);
        bus_write(chan_addr(0, periph_pkg::reg_control), 8'h01);
        wait_toggle(0, cycles);
        for (int n = 0; n < 3; n++) begin
            wait_toggle(0, cycles);
            assert (cycles == int'(r) + 1)
            else report_error($sformatf("toggle period %0d, expected %0d", cycles, r + 1));
        end
        bus_write(chan_addr(0, periph_pkg::reg_control), 8'h00);

        // interrupt and clear on channel 1
        r = 2 + ($urandom % 19);
        bus_write(chan_addr(1, periph_pkg::reg_reload_lo), 8'(r));
        bus_write(chan_addr(1, periph_pkg::reg_reload_hi), 8'h00);
        bus_write(chan_addr(1, periph_pkg::reg_control), 8'h03);
        wait_irq(1'b1);
        bus_read(periph_pkg::irq_offset, rd);
        expect_byte(rd, 8'h02, "irq summary");
        bus_read(chan_addr(1, periph_pkg::reg_status), rd);
        expect_byte(rd, 8'h03, "status of channel 1");
        bus_write(chan_addr(1, periph_pkg::reg_control), 8'h02);
        bus_write(chan_addr(1, periph_pkg::reg_status), 8'h01);
        wait_irq(1'b0);
        bus_read(chan_addr(1, periph_pkg::reg_status), rd);
        expect_byte(rd, 8'h00, "status of channel 1 after clear");

        // flag without irq_en on channel 2
        bus_write(chan_addr(2, periph_pkg::reg_reload_lo), 8'(2 + ($urandom % 19)));
        bus_write(chan_addr(2, periph_pkg::reg_reload_hi), 8'h00);
        bus_write(chan_addr(2, periph_pkg::reg_control), 8'h01);
        wait_flag(2);
        assert (interrupt_request === 1'b0)
        else report_error("interrupt_request set with irq_en clear");
        bus_read(periph_pkg::irq_offset, rd);
        expect_byte(rd, 8'h00, "irq summary with irq_en clear");
        bus_write(chan_addr(2, periph_pkg::reg_control), 8'h00);

        // one-shot on channel 3
        r = 2 + ($urandom % 19);
        bus_write(chan_addr(3, periph_pkg::reg_reload_lo), 8'(r));
        bus_write(chan_addr(3, periph_pkg::reg_reload_hi), 8'h00);
        bus_write(chan_addr(3, periph_pkg::reg_control), 8'h05);
        wait_toggle(3, cycles);
        bus_read(chan_addr(3, periph_pkg::reg_status), rd);
        expect_byte(rd, 8'h01, "status of channel 3 after one-shot");
        level = timer_out[3];
        repeat (3 * (r + 1)) begin
            next_cycle();
            assert (timer_out[3] === level)
            else report_error("timer_out[3] toggled after one-shot expiry");
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/periph_pkg.sv
design/timer_reg_if.sv
design/periph_addr_decoder.sv
design/periph_timer_channel.sv
design/periph_read_collector.sv
design/periph_timer_block.sv
tb/periph_timer_block_props.sv
tb/periph_timer_block_tb.sv
